// File: addrGenStage.sv
`timescale 1ns/1ps

module addrGenStage (
    input  logic                                CLK,
    input  logic                                RESET,
    input  logic                                issueValid,  // one-cycle issue strobe
    input  memOpPkg::memInstrU                  issueInstr,  // raw instruction word
    input  logic [coreCfgPkg::ADDR_WIDTH-1:0]   baseOperand, // value of the base register
    output logic                                enqueue,     // strobe into the queue
    output logic [memOpPkg::ENTRY_WIDTH-1:0]    entryIn      // packed entry for the queue
);

    logic                                  isLoad;
    logic                                  isStore;
    logic [memOpPkg::OFFSET_WIDTH-1:0]     offset;
    logic [coreCfgPkg::REG_IDX_WIDTH-1:0]  regIdx;
    logic [coreCfgPkg::ADDR_WIDTH-1:0]     effAddr;

    // --------------------
    // decode
    // --------------------
    assign isLoad  = (issueInstr.loadView.opcode == memOpPkg::OPC_LOAD);   // opcode bits line up
    assign isStore = (issueInstr.storeView.opcode == memOpPkg::OPC_STORE); // in both views

    always_comb begin
        if (isStore) begin
            offset = {issueInstr.storeView.offsetHi, issueInstr.storeView.offsetLo}; // rejoin split
            regIdx = issueInstr.storeView.srcReg;  // store carries its data register
        end else begin
            offset = issueInstr.loadView.offset;   // load offset is contiguous
            regIdx = issueInstr.loadView.destReg;  // load carries its destination
        end
    end

    // sign extend the offset and add it to the base operand
    assign effAddr = baseOperand
                   + {{(coreCfgPkg::ADDR_WIDTH - memOpPkg::OFFSET_WIDTH){offset[memOpPkg::OFFSET_WIDTH-1]}},
                      offset};

    // --------------------
    // entry register
    // --------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            enqueue <= 1'b0;
        end else begin
            enqueue <= issueValid && (isLoad || isStore); // other opcodes are dropped here
        end
    end

    always_ff @(posedge CLK) begin
        if (issueValid && (isLoad || isStore)) begin
            entryIn[memOpPkg::ENTRY_IS_STORE_BIT] <= isStore;
            entryIn[memOpPkg::ENTRY_REG_LSB +: coreCfgPkg::REG_IDX_WIDTH] <= regIdx;
            entryIn[memOpPkg::ENTRY_ADDR_LSB +: coreCfgPkg::ADDR_WIDTH] <= effAddr;
        end
    end

endmodule

// File: archRegFile.sv
`timescale 1ns/1ps

module archRegFile (
    input  logic                                 CLK,
    input  logic                                 RESET,
    input  logic                                 extWrEn,   // write from outside the pipe
    input  logic [coreCfgPkg::REG_IDX_WIDTH-1:0] extWrIdx,
    input  logic [coreCfgPkg::DATA_WIDTH-1:0]    extWrData,
    input  logic                                 ldWrEn,    // load write-back
    input  logic [coreCfgPkg::REG_IDX_WIDTH-1:0] ldWrIdx,
    input  logic [coreCfgPkg::DATA_WIDTH-1:0]    ldWrData,
    input  logic [coreCfgPkg::REG_IDX_WIDTH-1:0] rdIdx,     // store data read
    output logic [coreCfgPkg::DATA_WIDTH-1:0]    rdData
);

    logic [coreCfgPkg::DATA_WIDTH-1:0] regs [coreCfgPkg::REG_COUNT];

    // --------------------
    // write ports
    // --------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < coreCfgPkg::REG_COUNT; i++) begin
                regs[i] <= '0; // all registers start at zero
            end
        end else begin
            if (extWrEn) begin
                regs[extWrIdx] <= extWrData;
            end
            // later assignment wins, so a load to the same register overrides the external write
            if (ldWrEn) begin
                regs[ldWrIdx] <= ldWrData;
            end
        end
    end

    // --------------------
    // read port
    // --------------------
    // combinational, a store right after a load sees the value written at the edge between them
    assign rdData = regs[rdIdx];

endmodule

// File: coreCfgPkg.sv
package coreCfgPkg;

    // --------------------
    // datapath sizes
    // --------------------
    localparam int DATA_WIDTH = 32; // register and data memory word
    localparam int ADDR_WIDTH = 32; // byte address as produced by address generation

    // --------------------
    // register file sizes
    // --------------------
    localparam int REG_COUNT = 32;                 // architectural registers, no renaming
    localparam int REG_IDX_WIDTH = $clog2(REG_COUNT); // 5 bits to name one of them

endpackage

// File: loadStoreQueue.sv
`timescale 1ns/1ps

module loadStoreQueue #(
    parameter int QUEUE_SIZE = 8 // entries, a power of two and at least 2
) (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             enqueue,       // request to store entryIn
    input  logic [memOpPkg::ENTRY_WIDTH-1:0] entryIn,
    input  logic                             dequeue,       // request to pop the oldest entry
    output logic                             full,          // registered full flag
    output logic                             enqueueResult, // pulse, enqueue was taken
    output logic                             dequeueResult, // pulse, entryOut holds a new entry
    output logic [memOpPkg::ENTRY_WIDTH-1:0] entryOut       // last entry popped
);

    localparam int PTR_WIDTH = $clog2(QUEUE_SIZE);

    // pointers wrap on their own because the size is a power of two
    if (QUEUE_SIZE < 2 || (QUEUE_SIZE & (QUEUE_SIZE - 1)) != 0) begin : gSizeCheck
        $error("loadStoreQueue: QUEUE_SIZE must be a power of two, at least 2");
    end

    logic [memOpPkg::ENTRY_WIDTH-1:0] slots [QUEUE_SIZE];

    logic [PTR_WIDTH-1:0] head;     // oldest entry
    logic [PTR_WIDTH-1:0] tail;     // next free slot
    logic [PTR_WIDTH-1:0] headNext;
    logic [PTR_WIDTH-1:0] tailNext;
    logic                 fullReg;  // occupancy flag, tells full from empty when head equals tail
    logic                 isEmpty;
    logic                 doDeq;
    logic                 doEnq;

    // --------------------
    // accept decisions
    // --------------------
    assign headNext = head + PTR_WIDTH'(1);
    assign tailNext = tail + PTR_WIDTH'(1);
    assign isEmpty  = (head == tail) && !fullReg;

    assign doDeq = dequeue && !isEmpty;               // dequeue is decided first
    assign doEnq = enqueue && (!fullReg || doDeq);    // so a drained slot can be refilled at once

    // --------------------
    // pointers and flags
    // --------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            head          <= '0;
            tail          <= '0;
            fullReg       <= 1'b0;
            enqueueResult <= 1'b0;
            dequeueResult <= 1'b0;
        end else begin
            enqueueResult <= doEnq; // result pulses last a single cycle
            dequeueResult <= doDeq;
            if (doDeq) begin
                head <= headNext;
            end
            if (doEnq) begin
                tail <= tailNext;
            end
            if (doEnq && !doDeq && (tailNext == head)) begin
                fullReg <= 1'b1;     // last free slot just taken
            end else if (doDeq && !doEnq) begin
                fullReg <= 1'b0;     // a pop without a push always leaves room
            end
        end
    end

    assign full = fullReg;

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge CLK) begin
        if (doEnq) begin
            slots[tail] <= entryIn;
        end
        if (doDeq) begin
            entryOut <= slots[head]; // held when a dequeue finds the queue empty
        end
    end

endmodule

// File: memAccessStage.sv
`timescale 1ns/1ps

module memAccessStage #(
    parameter int MEM_WORDS = 256 // data memory depth in 32-bit words
) (
    input  logic                                 CLK,
    input  logic                                 RESET,
    input  logic                                 drainEnable,   // level, lets the queue drain
    input  logic                                 dequeueResult, // entryOut holds a fresh entry
    input  logic [memOpPkg::ENTRY_WIDTH-1:0]     entryOut,
    output logic                                 dequeue,
    output logic [coreCfgPkg::REG_IDX_WIDTH-1:0] rdIdx,         // store data register
    input  logic [coreCfgPkg::DATA_WIDTH-1:0]    rdData,
    output logic                                 ldWrEn,        // load write-back port
    output logic [coreCfgPkg::REG_IDX_WIDTH-1:0] ldWrIdx,
    output logic [coreCfgPkg::DATA_WIDTH-1:0]    ldWrData,
    output logic                                 doneValid,     // one pulse per operation
    output logic                                 doneIsStore,
    output logic [coreCfgPkg::REG_IDX_WIDTH-1:0] doneReg,
    output logic [coreCfgPkg::ADDR_WIDTH-1:0]    doneAddr,
    output logic [coreCfgPkg::DATA_WIDTH-1:0]    doneData
);

    localparam int MEM_IDX_WIDTH = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [coreCfgPkg::DATA_WIDTH-1:0] dataMem [MEM_WORDS];

    logic                                 entIsStore;
    logic [coreCfgPkg::REG_IDX_WIDTH-1:0] entReg;
    logic [coreCfgPkg::ADDR_WIDTH-1:0]    entAddr;
    logic [MEM_IDX_WIDTH-1:0]             wordIdx;
    logic [coreCfgPkg::DATA_WIDTH-1:0]    memRdData;
    logic                                 doStore;

    // --------------------
    // entry fields
    // --------------------
    assign entIsStore = entryOut[memOpPkg::ENTRY_IS_STORE_BIT];
    assign entReg     = entryOut[memOpPkg::ENTRY_REG_LSB +: coreCfgPkg::REG_IDX_WIDTH];
    assign entAddr    = entryOut[memOpPkg::ENTRY_ADDR_LSB +: coreCfgPkg::ADDR_WIDTH];

    // word address is the byte address without its low two bits, folded into the memory
    assign wordIdx = MEM_IDX_WIDTH'((entAddr >> 2) % MEM_WORDS);

    assign dequeue = drainEnable; // ask for one entry every cycle while draining

    // --------------------
    // data memory
    // --------------------
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            dataMem[i] = '0; // memory powers up cleared
        end
    end

    assign memRdData = dataMem[wordIdx]; // combinational read, used by loads
    assign doStore   = dequeueResult && entIsStore;

    always_ff @(posedge CLK) begin
        if (doStore) begin
            dataMem[wordIdx] <= rdData; // store lands on the same edge as its completion
        end
    end

    // --------------------
    // register file ports
    // --------------------
    assign rdIdx    = entReg;                        // a store names its source register
    assign ldWrEn   = dequeueResult && !entIsStore;  // a load names its destination
    assign ldWrIdx  = entReg;
    assign ldWrData = memRdData;

    // --------------------
    // completion report
    // --------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            doneValid <= 1'b0;
        end else begin
            doneValid <= dequeueResult; // every delivered entry completes next edge
        end
    end

    always_ff @(posedge CLK) begin
        if (dequeueResult) begin
            doneIsStore <= entIsStore;
            doneReg     <= entReg;
            doneAddr    <= entAddr;
            doneData    <= entIsStore ? rdData : memRdData; // value written or value loaded
        end
    end

endmodule

// File: memOpPkg.sv
package memOpPkg;

    // --------------------
    // opcodes
    // --------------------
    localparam logic [6:0] OPC_LOAD  = 7'b0000011; // word load, base plus contiguous offset
    localparam logic [6:0] OPC_STORE = 7'b0100011; // word store, offset split around the regs

    localparam int OFFSET_WIDTH = 12; // immediate offset, sign extended to an address

    // --------------------
    // instruction word
    // --------------------
    // the same 32 bits decode differently depending on the opcode in bits 6:0
    typedef union packed {
        struct packed {
            logic [OFFSET_WIDTH-1:0]              offset;   // whole signed offset
            logic [coreCfgPkg::REG_IDX_WIDTH-1:0] baseReg;  // base register field
            logic [2:0]                           funct;    // access size, word only here
            logic [coreCfgPkg::REG_IDX_WIDTH-1:0] destReg;  // register that takes the load
            logic [6:0]                           opcode;   // same position in both views
        } loadView;
        struct packed {
            logic [6:0]                           offsetHi; // offset bits 11:5
            logic [coreCfgPkg::REG_IDX_WIDTH-1:0] srcReg;   // register that holds store data
            logic [coreCfgPkg::REG_IDX_WIDTH-1:0] baseReg;  // base register field
            logic [2:0]                           funct;    // access size, word only here
            logic [4:0]                           offsetLo; // offset bits 4:0
            logic [6:0]                           opcode;   // same position in both views
        } storeView;
    } memInstrU;

    // --------------------
    // queue entry layout
    // --------------------
    // from the top: store bit, register index, byte address
    localparam int ENTRY_ADDR_LSB     = 0;
    localparam int ENTRY_REG_LSB      = ENTRY_ADDR_LSB + coreCfgPkg::ADDR_WIDTH;
    localparam int ENTRY_IS_STORE_BIT = ENTRY_REG_LSB + coreCfgPkg::REG_IDX_WIDTH;
    localparam int ENTRY_WIDTH        = ENTRY_IS_STORE_BIT + 1; // 1 + 5 + 32 = 38

endpackage

// File: memPipeProps.sv
`timescale 1ns/1ps

module memPipeProps (
    input logic CLK,
    input logic RESET,
    input logic full,          // registered full flag of the queue
    input logic enqueueResult, // enqueue was taken at the last edge
    input logic dequeueResult  // dequeue was taken at the last edge
);

    int occupancy; // entries held, rebuilt from the result pulses alone

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(enqueueResult) - int'(dequeueResult);
        end
    end

    // --------------------
    // acceptance rules
    // --------------------
    // a full queue only takes an entry in a cycle that also drains one
    enqFullNeedsDeq: assert property (@(posedge CLK) disable iff (!RESET)
        enqueueResult && $past(full) |-> dequeueResult)
        else $error("queue took an entry while full without draining one");

    // an empty queue has nothing to hand out
    deqNotEmpty: assert property (@(posedge CLK) disable iff (!RESET)
        dequeueResult |-> occupancy > 0)
        else $error("queue reported a dequeue while it was empty");

    // --------------------
    // full flag
    // --------------------
    fullFallsOnDeq: assert property (@(posedge CLK) disable iff (!RESET)
        $fell(full) |-> dequeueResult)
        else $error("full flag dropped with no dequeue");

endmodule

// File: memPipeTb.sv
`timescale 1ns/1ps

module memPipeTb;

    localparam int RAND_CYCLES = 300;              // length of the random mix
    localparam int MAX_OPS     = 40 + RAND_CYCLES; // upper bound on issued operations

    logic CLK, RESET, issueValid, drainEnable, regWrEn;
    logic [31:0] issueInstr, baseOperand, regWrData;
    logic [4:0] regWrIdx;
    logic issueAccepted, queueFull, doneValid, doneIsStore;
    logic [4:0] doneReg;
    logic [31:0] doneAddr, doneData;

    logic [31:0] shReg [32];      // shadow register file
    logic [31:0] shMem [256];     // shadow data memory
    logic [37:0] mQ [$];          // queue model holding {isStore, reg, addr} entries
    logic [69:0] expQ [$];        // expected completions as {entry, data}
    logic agV, dqV, mAccept, mFull, mDone;
    logic [37:0] agE, dqE;
    int acceptCount = 0;
    int doneCount = 0;
    logic [31:0] lastDoneData;

    memPipeTop #(.QUEUE_SIZE(8), .MEM_WORDS(256)) u_dut (.*);

    bind loadStoreQueue memPipeProps u_props (
        .CLK(CLK), .RESET(RESET), .full(full), .enqueueResult(enqueueResult),
        .dequeueResult(dequeueResult)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK; // 10 ns period
    end

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    // returns {valid, isStore, reg, addr} with the offset contiguous for a load and split for a store
    function automatic logic [38:0] decodeInstr(input logic [31:0] instr, input logic [31:0] base);
        logic [11:0] off;
        logic isSt;
        logic isLd;
        isSt = (instr[6:0] == memOpPkg::OPC_STORE);
        isLd = (instr[6:0] == memOpPkg::OPC_LOAD);
        off = isSt ? {instr[31:25], instr[11:7]} : instr[31:20];
        return {isLd || isSt, isSt, (isSt ? instr[24:20] : instr[11:7]),
                base + {{20{off[11]}}, off}};
    endfunction

    // a store takes its register, a load takes the memory word at addr bits 9:2
    function automatic logic [69:0] predictCompletion(input logic [37:0] e);
        logic [31:0] data;
        data = e[37] ? shReg[e[36:32]] : shMem[e[9:2]];
        return {e, data};
    endfunction

    always @(posedge CLK or negedge RESET) begin : refModel
        logic [69:0] rec;
        logic [38:0] dec;
        logic deq;
        logic enq;
        if (!RESET) begin
            for (int i = 0; i < 32; i++) shReg[i] = '0;
            for (int i = 0; i < 256; i++) shMem[i] = '0;
            mQ.delete();
            {agV, dqV, mAccept, mFull, mDone} = '0;
        end else begin
            mDone = dqV;                           // memory stage finishes what was delivered
            if (dqV) begin
                rec = predictCompletion(dqE);      // reads state from before this edge
                expQ.push_back(rec);
                if (dqE[37]) shMem[dqE[9:2]] = rec[31:0];
            end
            deq = drainEnable && (mQ.size() > 0);  // dequeue decided first
            enq = agV && (mQ.size() < 8 || deq);
            dqV = deq;
            if (deq) dqE = mQ.pop_front();
            if (enq) mQ.push_back(agE);
            mAccept = enq;
            mFull = (mQ.size() == 8);
            dec = decodeInstr(issueInstr, baseOperand);
            agV = issueValid && dec[38];
            agE = dec[37:0];
            if (regWrEn) shReg[regWrIdx] = regWrData;
            if (mDone && !rec[69]) shReg[rec[68:64]] = rec[31:0]; // load beats external write
        end
    end

    // --------------------
    // comparison
    // --------------------
    always @(negedge CLK) begin : compare
        logic [69:0] exp;
        if (RESET) begin
            checkEq(issueAccepted, mAccept, "issueAccepted");
            checkEq(queueFull, mFull, "queueFull");
            checkEq(doneValid, mDone, "doneValid");
            if (issueAccepted) acceptCount++;
            if (doneValid) begin
                exp = expQ.pop_front();
                checkEq(doneIsStore, exp[69], "doneIsStore");
                checkEq(doneReg, exp[68:64], "doneReg");
                checkEq(doneAddr, exp[63:32], "doneAddr");
                checkEq(doneData, exp[31:0], "doneData");
                lastDoneData = doneData;
                doneCount++;
            end
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------
    function automatic logic [31:0] loadInstr(input logic [4:0] rd, input logic [11:0] off);
        return {off, 5'd0, 3'b010, rd, memOpPkg::OPC_LOAD};
    endfunction

    function automatic logic [31:0] storeInstr(input logic [4:0] rs, input logic [11:0] off);
        return {off[11:5], rs, 5'd0, 3'b010, off[4:0], memOpPkg::OPC_STORE};
    endfunction

    task automatic driveCycle(input logic v, input logic [31:0] instr, input logic [31:0] base,
                              input logic we, input logic [4:0] wIdx, input logic [31:0] wData);
        @(posedge CLK);
        #1;
        issueValid = v;
        issueInstr = instr;
        baseOperand = base;
        regWrEn = we;
        regWrIdx = wIdx;
        regWrData = wData;
    endtask

    task automatic waitDrained();
        repeat (3) @(posedge CLK);                // accept shows two edges after issue
        while (doneCount != acceptCount) @(posedge CLK);
    endtask

    initial begin
        #((MAX_OPS * 20 + 200) * 10);
        $display("Timeout: the pipeline stopped completing operations");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int startAcc;
        logic [31:0] r;
        r = $urandom(26);
        {RESET, issueValid, drainEnable, regWrEn, regWrIdx} = '0;
        {issueInstr, baseOperand, regWrData} = '0;
        repeat (8) @(posedge CLK);
        #1 RESET = 1'b1;
        @(negedge CLK);
        checkEq(queueFull, 0, "queueFull after reset");
        checkEq(issueAccepted, 0, "issueAccepted after reset");
        checkEq(doneValid, 0, "doneValid after reset");
        // store then load through the same word, then store the loaded register
        driveCycle(0, 0, 0, 1, 5, 32'hDEADBEEF);
        drainEnable = 1'b1;
        driveCycle(1, storeInstr(5, 12'hFFC), 32'h100, 1, 6, 32'h12345678); // 0x100 - 4
        driveCycle(1, loadInstr(7, 12'h00C), 32'h0F0, 0, 0, 0);             // same word 0xFC
        driveCycle(1, storeInstr(7, 12'h7E4), 32'h200, 0, 0, 0);            // split positive
        driveCycle(0, 0, 0, 0, 0, 0);
        waitDrained();
        checkEq(lastDoneData, 32'hDEADBEEF, "store of the loaded register");
        // fill the queue with draining off
        startAcc = acceptCount;
        driveCycle(0, 0, 0, 0, 0, 0);
        drainEnable = 1'b0;
        for (int i = 0; i < 10; i++) driveCycle(1, loadInstr(i + 1, i * 4), 32'h300, 0, 0, 0);
        driveCycle(0, 0, 0, 0, 0, 0);
        repeat (4) driveCycle(0, 0, 0, 0, 0, 0);
        checkEq(acceptCount - startAcc, 8, "accepted issues into a blocked queue");
        checkEq(queueFull, 1, "queueFull with draining off");
        // issue lands in the same cycle that the first entry drains
        driveCycle(1, storeInstr(3, 12'h010), 32'h300, 0, 0, 0);
        driveCycle(0, 0, 0, 0, 0, 0);
        drainEnable = 1'b1;
        waitDrained();
        checkEq(acceptCount - startAcc, 9, "issue accepted while draining a full queue");
        // non-memory opcodes are dropped
        startAcc = acceptCount;
        driveCycle(1, 32'h00500093, 32'h40, 0, 0, 0);
        driveCycle(1, 32'h00B50533, 32'h40, 0, 0, 0);
        repeat (5) driveCycle(0, 0, 0, 0, 0, 0);
        checkEq(acceptCount, startAcc, "non-memory opcode accepted");
        // random mix
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = $urandom;
            case (r[1:0])
                2'd0: driveCycle(1, loadInstr($urandom, $urandom), ($urandom % 128) << 2,
                                 r[2], $urandom, $urandom);
                2'd1: driveCycle(1, storeInstr($urandom, $urandom), ($urandom % 128) << 2,
                                 r[2], $urandom, $urandom);
                2'd2: driveCycle(1, {$urandom, 7'h13}, $urandom, r[2], $urandom, $urandom);
                default: driveCycle(0, 0, 0, r[2], $urandom, $urandom);
            endcase
            if (r[6:4] == 3'd0) drainEnable = ~drainEnable; // toggle now and then
        end
        driveCycle(0, 0, 0, 0, 0, 0);
        drainEnable = 1'b1;
        waitDrained();
        repeat (2) @(posedge CLK);
        if (expQ.size() != 0 || mQ.size() != 0) begin
            $display("Operations were predicted but never completed");
            $display(">>> FAIL");
            $fatal(1, "missing completions");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: memPipeTop.sv
`timescale 1ns/1ps

module memPipeTop #(
    parameter int QUEUE_SIZE = 8,   // queue entries, passed to the queue
    parameter int MEM_WORDS  = 256  // data memory depth, passed to the memory stage
) (
    input  logic                                 CLK,
    input  logic                                 RESET,
    input  logic                                 issueValid,
    input  logic [31:0]                          issueInstr,
    input  logic [coreCfgPkg::ADDR_WIDTH-1:0]    baseOperand,
    input  logic                                 drainEnable,
    input  logic                                 regWrEn,      // stands in for ALU write-back
    input  logic [coreCfgPkg::REG_IDX_WIDTH-1:0] regWrIdx,
    input  logic [coreCfgPkg::DATA_WIDTH-1:0]    regWrData,
    output logic                                 issueAccepted,
    output logic                                 queueFull,
    output logic                                 doneValid,
    output logic                                 doneIsStore,
    output logic [coreCfgPkg::REG_IDX_WIDTH-1:0] doneReg,
    output logic [coreCfgPkg::ADDR_WIDTH-1:0]    doneAddr,
    output logic [coreCfgPkg::DATA_WIDTH-1:0]    doneData
);

    // --------------------
    // stage wires
    // --------------------
    logic                                 enqueue;       // address generation to queue
    logic [memOpPkg::ENTRY_WIDTH-1:0]     entryIn;
    logic                                 dequeue;       // memory stage to queue
    logic                                 dequeueResult; // queue to memory stage
    logic [memOpPkg::ENTRY_WIDTH-1:0]     entryOut;
    logic [coreCfgPkg::REG_IDX_WIDTH-1:0] rdIdx;         // store data lookup
    logic [coreCfgPkg::DATA_WIDTH-1:0]    rdData;
    logic                                 ldWrEn;        // load write-back
    logic [coreCfgPkg::REG_IDX_WIDTH-1:0] ldWrIdx;
    logic [coreCfgPkg::DATA_WIDTH-1:0]    ldWrData;

    addrGenStage u_addrGen (
        .CLK(CLK), .RESET(RESET),
        .issueValid(issueValid), .issueInstr(issueInstr), .baseOperand(baseOperand),
        .enqueue(enqueue), .entryIn(entryIn)
    );

    loadStoreQueue #(.QUEUE_SIZE(QUEUE_SIZE)) u_queue (
        .CLK(CLK), .RESET(RESET),
        .enqueue(enqueue), .entryIn(entryIn), .dequeue(dequeue),
        .full(queueFull), .enqueueResult(issueAccepted),
        .dequeueResult(dequeueResult), .entryOut(entryOut)
    );

    memAccessStage #(.MEM_WORDS(MEM_WORDS)) u_memAccess (
        .CLK(CLK), .RESET(RESET),
        .drainEnable(drainEnable), .dequeueResult(dequeueResult), .entryOut(entryOut),
        .dequeue(dequeue), .rdIdx(rdIdx), .rdData(rdData),
        .ldWrEn(ldWrEn), .ldWrIdx(ldWrIdx), .ldWrData(ldWrData),
        .doneValid(doneValid), .doneIsStore(doneIsStore), .doneReg(doneReg),
        .doneAddr(doneAddr), .doneData(doneData)
    );

    archRegFile u_regFile (
        .CLK(CLK), .RESET(RESET),
        .extWrEn(regWrEn), .extWrIdx(regWrIdx), .extWrData(regWrData),
        .ldWrEn(ldWrEn), .ldWrIdx(ldWrIdx), .ldWrData(ldWrData),
        .rdIdx(rdIdx), .rdData(rdData)
    );

endmodule

// File: sources.f
coreCfgPkg.sv
memOpPkg.sv
addrGenStage.sv
loadStoreQueue.sv
memAccessStage.sv
archRegFile.sv
memPipeTop.sv
memPipeProps.sv
memPipeTb.sv
